/* hdl/video_pkg.sv */
package video_pkg;

  // channel and coordinate widths
  localparam int COLOR_DEPTH = 6;
  localparam int COORD_W     = 10;
  localparam int FRAME_W     = 8;

  typedef logic [COLOR_DEPTH-1:0] color_t; // 63 is full scale
  typedef logic [COORD_W-1:0]     coord_t;  // pixel or line index
  typedef logic [FRAME_W-1:0]     frame_t;  // wraps at 256

  // both syncs active low
  localparam logic SYNC_ACTIVE = 1'b0;

  // 640x480 at 60 Hz, 25 MHz pixel clock
  localparam int DEF_H_ACTIVE = 640;
  localparam int DEF_H_FP     = 16;
  localparam int DEF_H_SYNC   = 96;
  localparam int DEF_H_BP     = 48;

  localparam int DEF_V_ACTIVE = 480;
  localparam int DEF_V_FP     = 10;
  localparam int DEF_V_SYNC   = 2;
  localparam int DEF_V_BP     = 33;

  // half a second per LED step at 60 frames/s
  localparam int DEF_LED_DIV = 30;

  localparam int led_n = 5; // D1..D5 on the board

endpackage

/* hdl/reset_gen.sv */
`timescale 1ns/1ns

module reset_gen (
  input  logic CLK,
  input  logic arst_n,
  output logic rst_n
);

  logic [3:0] stretch_q; // fills with ones after release

  // asserts at once, releases on the 4th edge after arst_n rises
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      stretch_q <= '0;
    end else begin
      stretch_q <= {stretch_q[2:0], 1'b1};
    end
  end

  assign rst_n = stretch_q[3]; // top bit only, glitch free

endmodule

/* hdl/vga_timing.sv */
`timescale 1ns/1ns

module vga_timing #(
  parameter int H_ACTIVE = video_pkg::DEF_H_ACTIVE,
  parameter int H_FP     = video_pkg::DEF_H_FP,
  parameter int H_SYNC   = video_pkg::DEF_H_SYNC,
  parameter int H_BP     = video_pkg::DEF_H_BP,
  parameter int V_ACTIVE = video_pkg::DEF_V_ACTIVE,
  parameter int V_FP     = video_pkg::DEF_V_FP,
  parameter int V_SYNC   = video_pkg::DEF_V_SYNC,
  parameter int V_BP     = video_pkg::DEF_V_BP
) (
  input  logic              CLK,
  input  logic              rst_n,
  output video_pkg::coord_t x,
  output video_pkg::coord_t y,
  output logic              active,
  output logic              hs_pre,
  output logic              vs_pre,
  output video_pkg::frame_t frame,
  output logic              frame_start
);

  import video_pkg::*;

  localparam int H_TOTAL = H_ACTIVE + H_FP + H_SYNC + H_BP;
  localparam int V_TOTAL = V_ACTIVE + V_FP + V_SYNC + V_BP;

  localparam int H_SYNC_START = H_ACTIVE + H_FP;
  localparam int H_SYNC_END   = H_SYNC_START + H_SYNC; // first count after pulse
  localparam int V_SYNC_START = V_ACTIVE + V_FP;
  localparam int V_SYNC_END   = V_SYNC_START + V_SYNC;

  coord_t h_cnt;
  coord_t v_cnt;
  logic   h_last;
  logic   v_last;
  logic   at_origin;
  logic   in_active;
  logic   h_sync_on;
  logic   v_sync_on;
  logic   first_frame; // no increment on the first origin

  assign h_last    = (h_cnt == coord_t'(H_TOTAL - 1));
  assign v_last    = (v_cnt == coord_t'(V_TOTAL - 1));
  assign at_origin = (h_cnt == '0) && (v_cnt == '0);
  assign in_active = (h_cnt < coord_t'(H_ACTIVE)) && (v_cnt < coord_t'(V_ACTIVE));

  assign h_sync_on = (h_cnt >= coord_t'(H_SYNC_START)) && (h_cnt < coord_t'(H_SYNC_END));
  assign v_sync_on = (v_cnt >= coord_t'(V_SYNC_START)) && (v_cnt < coord_t'(V_SYNC_END));

  // raster counters, line advances on pixel wrap
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      h_cnt <= '0;
      v_cnt <= '0;
    end else begin
      if (h_last) begin
        h_cnt <= '0;
        if (v_last) begin
          v_cnt <= '0;
        end else begin
          v_cnt <= v_cnt + 1'b1;
        end
      end else begin
        h_cnt <= h_cnt + 1'b1;
      end
    end
  end

  // registered outputs, all aligned to the same count
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      x           <= '0;
      y           <= '0;
      active      <= 1'b0;
      hs_pre      <= ~SYNC_ACTIVE;
      vs_pre      <= ~SYNC_ACTIVE;
      frame_start <= 1'b0;
      frame       <= '0;
      first_frame <= 1'b1;
    end else begin
      x           <= h_cnt;
      y           <= v_cnt;
      active      <= in_active;
      hs_pre      <= h_sync_on ? SYNC_ACTIVE : ~SYNC_ACTIVE;
      vs_pre      <= v_sync_on ? SYNC_ACTIVE : ~SYNC_ACTIVE;
      frame_start <= at_origin;
      if (at_origin) begin
        first_frame <= 1'b0;
        if (!first_frame) begin
          frame <= frame + 1'b1; // wraps
        end
      end
    end
  end

endmodule

/* hdl/pattern_gen.sv */
`timescale 1ns/1ns

module pattern_gen (
  input  logic              CLK,
  input  logic              rst_n,
  input  video_pkg::coord_t x,
  input  video_pkg::coord_t y,
  input  logic              active,
  input  logic              hs_pre,
  input  logic              vs_pre,
  input  video_pkg::frame_t frame,
  output video_pkg::color_t r,
  output video_pkg::color_t g,
  output video_pkg::color_t b,
  output logic              hs,
  output logic              vs
);

  import video_pkg::*;

  color_t r_next;
  color_t g_next;
  color_t b_next;

  // red scrolls one step per frame
  assign r_next = x[COLOR_DEPTH-1:0] + frame[COLOR_DEPTH-1:0];
  assign g_next = y[COLOR_DEPTH-1:0];
  assign b_next = x[COLOR_DEPTH-1:0] ^ y[COLOR_DEPTH-1:0]; // checker texture

  // single stage, color blanked outside active area
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      r <= '0;
      g <= '0;
      b <= '0;
    end else begin
      if (active) begin
        r <= r_next;
        g <= g_next;
        b <= b_next;
      end else begin
        r <= '0;
        g <= '0;
        b <= '0;
      end
    end
  end

  // syncs ride the same stage as the color
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      hs <= ~SYNC_ACTIVE;
      vs <= ~SYNC_ACTIVE;
    end else begin
      hs <= hs_pre;
      vs <= vs_pre;
    end
  end

endmodule

/* hdl/led_chaser.sv */
`timescale 1ns/1ns

module led_chaser #(
  parameter int LED_DIV = video_pkg::DEF_LED_DIV
) (
  input  logic                       CLK,
  input  logic                       rst_n,
  input  logic                       frame_start,
  output logic [video_pkg::led_n-1:0] led
);

  import video_pkg::*;

  localparam int DIV_W = (LED_DIV > 1) ? $clog2(LED_DIV) : 1;

  logic [DIV_W-1:0] div_cnt; // frames since last step
  logic             div_wrap;

  assign div_wrap = (div_cnt == DIV_W'(LED_DIV - 1));

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      div_cnt <= '0;
      led     <= led_n'(1); // D1 lit
    end else if (frame_start) begin
      if (div_wrap) begin
        div_cnt <= '0;
        led     <= {led[led_n-2:0], led[led_n-1]}; // one place up, wraps
      end else begin
        div_cnt <= div_cnt + 1'b1;
      end
    end
  end

endmodule

/* hdl/board_top.sv */
`timescale 1ns/1ns

module board_top #(
  parameter int H_ACTIVE = video_pkg::DEF_H_ACTIVE,
  parameter int H_FP     = video_pkg::DEF_H_FP,
  parameter int H_SYNC   = video_pkg::DEF_H_SYNC,
  parameter int H_BP     = video_pkg::DEF_H_BP,
  parameter int V_ACTIVE = video_pkg::DEF_V_ACTIVE,
  parameter int V_FP     = video_pkg::DEF_V_FP,
  parameter int V_SYNC   = video_pkg::DEF_V_SYNC,
  parameter int V_BP     = video_pkg::DEF_V_BP,
  parameter int LED_DIV  = video_pkg::DEF_LED_DIV
) (
  input  logic                        CLK,
  input  logic                        arst_n,
  output video_pkg::color_t           r,   // PMOD1..4, PMOD8..9
  output video_pkg::color_t           g,   // TR10..TR5
  output video_pkg::color_t           b,   // BR10..BR5
  output logic                        hs,  // PMOD7
  output logic                        vs,  // PMOD10
  output logic [video_pkg::led_n-1:0] led  // D1..D5
);

  import video_pkg::*;

  logic   rst_n;
  coord_t pix_x;
  coord_t pix_y;
  logic   pix_active;
  logic   hs_pre;
  logic   vs_pre;
  frame_t frame;
  logic   frame_start;

  reset_gen i_reset_gen (
    .CLK    (CLK),
    .arst_n (arst_n),
    .rst_n  (rst_n)
  );

  vga_timing #(
    .H_ACTIVE (H_ACTIVE),
    .H_FP     (H_FP),
    .H_SYNC   (H_SYNC),
    .H_BP     (H_BP),
    .V_ACTIVE (V_ACTIVE),
    .V_FP     (V_FP),
    .V_SYNC   (V_SYNC),
    .V_BP     (V_BP)
  ) i_vga_timing (
    .CLK         (CLK),
    .rst_n       (rst_n),
    .x           (pix_x),
    .y           (pix_y),
    .active      (pix_active),
    .hs_pre      (hs_pre),
    .vs_pre      (vs_pre),
    .frame       (frame),
    .frame_start (frame_start)
  );

  pattern_gen i_pattern_gen (
    .CLK    (CLK),
    .rst_n  (rst_n),
    .x      (pix_x),
    .y      (pix_y),
    .active (pix_active),
    .hs_pre (hs_pre),
    .vs_pre (vs_pre),
    .frame  (frame),
    .r      (r),
    .g      (g),
    .b      (b),
    .hs     (hs),
    .vs     (vs)
  );

  led_chaser #(
    .LED_DIV (LED_DIV)
  ) i_led_chaser (
    .CLK         (CLK),
    .rst_n       (rst_n),
    .frame_start (frame_start),
    .led         (led)
  );

endmodule

/* bench/board_sva.sv */
`timescale 1ns/1ns

module board_sva #(
  parameter int H_SYNC  = video_pkg::DEF_H_SYNC,
  parameter int V_SYNC  = video_pkg::DEF_V_SYNC,
  parameter int H_TOTAL = 800
) (
  input logic              CLK,
  input logic              rst_n,
  input logic              active,
  input logic              hs_pre,
  input logic              vs_pre,
  input video_pkg::color_t r,
  input video_pkg::color_t g,
  input video_pkg::color_t b,
  input logic              hs,
  input logic              vs
);

  import video_pkg::*;

  int hs_low_cnt; // cycles of the current hs pulse
  int vs_low_cnt;

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      hs_low_cnt <= 0;
      vs_low_cnt <= 0;
    end else begin
      hs_low_cnt <= (hs == SYNC_ACTIVE) ? hs_low_cnt + 1 : 0;
      vs_low_cnt <= (vs == SYNC_ACTIVE) ? vs_low_cnt + 1 : 0;
    end
  end

  // sync intervals lie in the blanking area
  sync_outside_active: assert property (@(posedge CLK) disable iff (!rst_n)
    active |-> (hs_pre != SYNC_ACTIVE) && (vs_pre != SYNC_ACTIVE))
    else $error("sync asserted inside the active area");

  blank_during_sync: assert property (@(posedge CLK) disable iff (!rst_n)
    ((hs == SYNC_ACTIVE) || (vs == SYNC_ACTIVE)) |-> (r == '0) && (g == '0) && (b == '0))
    else $error("color not blanked during sync");

  hs_width: assert property (@(posedge CLK) disable iff (!rst_n)
    $rose(hs) |-> (hs_low_cnt == H_SYNC))
    else $error("hs pulse width wrong");

  vs_width: assert property (@(posedge CLK) disable iff (!rst_n)
    $rose(vs) |-> (vs_low_cnt == V_SYNC * H_TOTAL))
    else $error("vs pulse width wrong");

endmodule

// sized for the tiny raster in board_tb
bind pattern_gen board_sva #(
  .H_SYNC  (3),
  .V_SYNC  (2),
  .H_TOTAL (24)
) i_board_sva (
  .CLK    (CLK),
  .rst_n  (rst_n),
  .active (active),
  .hs_pre (hs_pre),
  .vs_pre (vs_pre),
  .r      (r),
  .g      (g),
  .b      (b),
  .hs     (hs),
  .vs     (vs)
);

/* bench/board_tb.sv */
`timescale 1ns/1ns

module board_tb;

  import video_pkg::*;

  localparam int H_ACTIVE = 16;
  localparam int H_FP     = 2;
  localparam int H_SYNC   = 3;
  localparam int H_BP     = 3;
  localparam int V_ACTIVE = 8;
  localparam int V_FP     = 1;
  localparam int V_SYNC   = 2;
  localparam int V_BP     = 2;
  localparam int LED_DIV  = 2;

  localparam int H_TOTAL     = H_ACTIVE + H_FP + H_SYNC + H_BP;
  localparam int V_TOTAL     = V_ACTIVE + V_FP + V_SYNC + V_BP;
  localparam int FRAME_CYC   = H_TOTAL * V_TOTAL;
  localparam int LATENCY     = 6; // stretch 4, timing 1, pattern 1
  localparam int RESET_CYC   = 16;
  localparam int N_FRAMES    = 12;
  localparam int N_PROBES    = 2 * N_FRAMES;
  localparam int MID_POS     = 157; // line 6, pixel 13
  localparam int TIMEOUT_CYC = 14 * FRAME_CYC + 500;

  logic              CLK;
  logic              arst_n;
  color_t            r;
  color_t            g;
  color_t            b;
  logic              hs;
  logic              vs;
  logic [led_n-1:0]  led;

  int                       probe_frame [N_PROBES];
  int                       probe_x     [N_PROBES];
  int                       probe_y     [N_PROBES];
  logic [3*COLOR_DEPTH-1:0] probe_rgb   [N_PROBES];

  logic [31:0] rng_state;
  int          wd_cycles = 0;
  bit          in_reset;
  int          k_rel; // negedges since reset release
  int          checks, errors;
  int          err_sync, err_color, err_blank, err_led, err_probe;
  logic        hs_prev, vs_prev;
  int          hs_run, vs_run, hs_pulses, vs_periods, vs_fall_at;
  bit          vs_fall_seen;
  int          tests_run, tests_failed;

  board_top #(
    .H_ACTIVE (H_ACTIVE), .H_FP (H_FP), .H_SYNC (H_SYNC), .H_BP (H_BP),
    .V_ACTIVE (V_ACTIVE), .V_FP (V_FP), .V_SYNC (V_SYNC), .V_BP (V_BP),
    .LED_DIV  (LED_DIV)
  ) i_dut (
    .CLK    (CLK),
    .arst_n (arst_n),
    .r      (r),
    .g      (g),
    .b      (b),
    .hs     (hs),
    .vs     (vs),
    .led    (led)
  );

  always #4 CLK = ~CLK;

  always @(posedge CLK) begin
    wd_cycles++;
    if (wd_cycles > TIMEOUT_CYC) begin
      $display("timeout: the run went past %0d clock cycles", TIMEOUT_CYC);
      $display("sim failed");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] v;
    v = s;
    v ^= v << 13;
    v ^= v >> 17;
    v ^= v << 5;
    return v;
  endfunction

  // red scrolls with frame, green follows line, blue is x xor y
  function automatic logic [3*COLOR_DEPTH-1:0] color_rule(input int f, input int px,
                                                          input int py);
    logic [COLOR_DEPTH-1:0] rr, gg, bb;
    rr = COLOR_DEPTH'((px + f) % 64);
    gg = COLOR_DEPTH'(py % 64);
    bb = COLOR_DEPTH'((px % 64) ^ (py % 64));
    return {rr, gg, bb};
  endfunction

  // first frame_start also counts so the first step comes after LED_DIV-1 frames
  function automatic logic [led_n-1:0] led_rule(input int f);
    int steps;
    steps = ((f + 1) / LED_DIV) % led_n;
    return led_n'(1 << steps);
  endfunction

  function automatic int probe_pos(input int idx);
    return probe_frame[idx] * FRAME_CYC + probe_y[idx] * H_TOTAL + probe_x[idx];
  endfunction

  task automatic build_probe_table();
    int fi, j, t;
    for (fi = 0; fi < N_FRAMES; fi++) begin
      for (j = 2 * fi; j < 2 * fi + 2; j++) begin
        rng_state      = xorshift32(rng_state);
        probe_x[j]     = int'(rng_state % H_ACTIVE);
        rng_state      = xorshift32(rng_state);
        probe_y[j]     = 1 + int'(rng_state % (V_ACTIVE - 1)); // line 0 is already past
        probe_frame[j] = fi;
      end
      if (probe_pos(2 * fi) > probe_pos(2 * fi + 1)) begin
        t = probe_x[2 * fi];
        probe_x[2 * fi] = probe_x[2 * fi + 1];
        probe_x[2 * fi + 1] = t;
        t = probe_y[2 * fi];
        probe_y[2 * fi] = probe_y[2 * fi + 1];
        probe_y[2 * fi + 1] = t;
      end
    end
    for (j = 0; j < N_PROBES; j++) begin
      probe_rgb[j] = color_rule(probe_frame[j] % 256, probe_x[j], probe_y[j]);
    end
  endtask

  task automatic report_error(input string msg);
    errors++;
    $display("FAILED at %0t: %s", $time, msg);
  endtask

  task automatic check_outputs();
    int n, h, v, f;
    bit act;
    logic [3*COLOR_DEPTH-1:0] exp_rgb;
    logic exp_hs, exp_vs;
    logic [led_n-1:0] exp_led;
    if (in_reset || k_rel < LATENCY) begin
      checks++;
      if ({r, g, b} !== '0 || hs !== 1'b1 || vs !== 1'b1 || led !== led_n'(1)) begin
        report_error($sformatf("reset values wrong: rgb %h hs %b vs %b led %b",
                               {r, g, b}, hs, vs, led));
      end
    end else begin
      n       = k_rel - LATENCY;
      h       = n % H_TOTAL;
      v       = (n / H_TOTAL) % V_TOTAL;
      f       = n / FRAME_CYC;
      act     = (h < H_ACTIVE) && (v < V_ACTIVE);
      exp_rgb = act ? color_rule(f % 256, h, v) : '0;
      exp_hs  = !((h >= H_ACTIVE + H_FP) && (h < H_ACTIVE + H_FP + H_SYNC));
      exp_vs  = !((v >= V_ACTIVE + V_FP) && (v < V_ACTIVE + V_FP + V_SYNC));
      exp_led = led_rule(f);
      checks += 3;
      if ({r, g, b} !== exp_rgb) begin
        if (act) begin
          err_color++;
        end else begin
          err_blank++;
        end
        report_error($sformatf("rgb %h, expected %h at x %0d y %0d frame %0d",
                               {r, g, b}, exp_rgb, h, v, f));
      end
      if (hs !== exp_hs || vs !== exp_vs) begin
        err_sync++;
        report_error($sformatf("hs %b vs %b, expected %b %b at x %0d y %0d",
                               hs, vs, exp_hs, exp_vs, h, v));
      end
      if (led !== exp_led) begin
        err_led++;
        report_error($sformatf("led %b, expected %b in frame %0d", led, exp_led, f));
      end
    end
  endtask

  // pulse widths and frame period measured from the pins
  task automatic track_sync();
    if (in_reset || k_rel < LATENCY) begin
      hs_prev      = 1'b1;
      vs_prev      = 1'b1;
      hs_run       = 0;
      vs_run       = 0;
      vs_fall_seen = 1'b0;
    end else begin
      if (hs == 1'b0) begin
        hs_run++;
      end else if (hs_prev == 1'b0) begin
        hs_pulses++;
        checks++;
        if (hs_run != H_SYNC) begin
          err_sync++;
          report_error($sformatf("hs low for %0d cycles, expected %0d", hs_run, H_SYNC));
        end
        hs_run = 0;
      end
      if (vs == 1'b0) begin
        vs_run++;
        if (vs_prev == 1'b1) begin
          if (vs_fall_seen) begin
            vs_periods++;
            checks++;
            if (k_rel - vs_fall_at != FRAME_CYC) begin
              err_sync++;
              report_error($sformatf("frame period %0d cycles, expected %0d",
                                     k_rel - vs_fall_at, FRAME_CYC));
            end
          end
          vs_fall_seen = 1'b1;
          vs_fall_at   = k_rel;
        end
      end else if (vs_prev == 1'b0) begin
        checks++;
        if (vs_run != V_SYNC * H_TOTAL) begin
          err_sync++;
          report_error($sformatf("vs low for %0d cycles, expected %0d",
                                 vs_run, V_SYNC * H_TOTAL));
        end
        vs_run = 0;
      end
      hs_prev = hs;
      vs_prev = vs;
    end
  endtask

  task automatic advance_cycle();
    @(negedge CLK);
    if (!in_reset) begin
      k_rel++;
    end
    check_outputs();
    track_sync();
  endtask

  task automatic assert_reset();
    arst_n  <= 1'b0;
    in_reset = 1'b1;
  endtask

  task automatic release_reset();
    arst_n  <= 1'b1;
    in_reset = 1'b0;
    k_rel    = 0;
  endtask

  task automatic finish_test(input string name, input int errs);
    tests_run++;
    if (errs == 0) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", tests_run, name, errs);
    end
  endtask

  initial begin
    int snap;
    int idx;
    CLK       = 1'b0;
    arst_n    = 1'b0;
    in_reset  = 1'b1;
    k_rel     = 0;
    rng_state = 32'd78;
    build_probe_table();

    snap = errors;
    repeat (RESET_CYC) advance_cycle();
    release_reset();
    while (k_rel < LATENCY + 2) advance_cycle(); // pixel (1,0) is the first nonzero one
    finish_test("reset values and first pixel latency", errors - snap);

    for (idx = 0; idx < N_PROBES; idx++) begin
      while (k_rel - LATENCY < probe_pos(idx)) advance_cycle();
      checks++;
      if ({r, g, b} !== probe_rgb[idx]) begin
        err_probe++;
        report_error($sformatf("probe %0d rgb %h, expected %h at x %0d y %0d frame %0d",
                               idx, {r, g, b}, probe_rgb[idx], probe_x[idx],
                               probe_y[idx], probe_frame[idx]));
      end
    end
    if (hs_pulses < (N_FRAMES - 1) * V_TOTAL || vs_periods < N_FRAMES - 2) begin
      err_sync++;
      errors++;
      $display("too few sync pulses were seen: %0d hs pulses, %0d frame periods",
               hs_pulses, vs_periods);
    end
    finish_test("sync widths and frame period", err_sync);
    finish_test("pixel colors and probe table", err_color + err_probe);
    finish_test("blanking outside active area", err_blank);
    finish_test("led chaser rotation", err_led);

    snap = errors;
    while ((k_rel - LATENCY) % FRAME_CYC != MID_POS) advance_cycle();
    assert_reset();
    #1;
    check_outputs(); // outputs must clear before the next edge
    repeat (5) advance_cycle();
    release_reset();
    while (k_rel < LATENCY + FRAME_CYC + H_TOTAL) advance_cycle();
    finish_test("reset in mid-frame", errors - snap);

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

/* build.f */
hdl/video_pkg.sv
hdl/reset_gen.sv
hdl/vga_timing.sv
hdl/pattern_gen.sv
hdl/led_chaser.sv
hdl/board_top.sv
bench/board_sva.sv
bench/board_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# compile and run the board testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module board_tb \
  -f build.f \
  -Mdir obj_dir

./obj_dir/Vboard_tb 2>&1 | tee sim.log

if grep -qx "sim passed" sim.log; then
  echo "run_sim: PASS"
else
  echo "run_sim: FAIL"
  exit 1
fi
